//--- include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// unified memory depth in 32-bit words
`define CPU_MEM_WORDS 1024

// word index width, log2 of the depth
`define CPU_MEM_AW 10

// first fetch address once run_i goes high
`define CPU_RESET_PC 32'h0000_0000

`endif

//--- src/cpu_pkg.sv
package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [3:0] strb_t;

	// rv32i major opcodes, only the supported subset
	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_JAL    = 7'b1101111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011,
		OP_SYSTEM = 7'b1110011
	} opcode_e;

	// multi-cycle core sequencing
	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH,
		S_EXEC,
		S_MEM,
		S_WB,
		S_HALT
	} core_state_e;

endpackage

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic             clock,
	input  logic             arst_n_i,
	input  cpu_pkg::reg_idx_t raddr1_i,
	input  cpu_pkg::reg_idx_t raddr2_i,
	output cpu_pkg::word_t   rdata1_o,
	output cpu_pkg::word_t   rdata2_o,
	input  logic             we_i,
	input  cpu_pkg::reg_idx_t waddr_i,
	input  cpu_pkg::word_t   wdata_i
);
	import cpu_pkg::*;

	word_t regs [32];

	// x0 is never written so it keeps its reset value
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

endmodule

//--- src/rv_core.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module rv_core (
	input  logic              clock,
	input  logic              arst_n_i,
	input  logic              run_i,
	output logic              fetch_req_o,
	output cpu_pkg::addr_t    fetch_addr_o,
	input  logic              fetch_done_i,
	input  cpu_pkg::word_t    fetch_rdata_i,
	output logic              data_req_o,
	output logic              data_we_o,
	output cpu_pkg::addr_t    data_addr_o,
	output cpu_pkg::word_t    data_wdata_o,
	output cpu_pkg::strb_t    data_strb_o,
	input  logic              data_done_i,
	input  cpu_pkg::word_t    data_rdata_i,
	output cpu_pkg::reg_idx_t rs1_addr_o,
	output cpu_pkg::reg_idx_t rs2_addr_o,
	input  cpu_pkg::word_t    rs1_data_i,
	input  cpu_pkg::word_t    rs2_data_i,
	output logic              rd_we_o,
	output cpu_pkg::reg_idx_t rd_addr_o,
	output cpu_pkg::word_t    rd_wdata_o,
	output logic              halted_o
);
	import cpu_pkg::*;

	core_state_e state_q;
	core_state_e resume_state;
	addr_t       pc_q;
	addr_t       next_pc;
	word_t       ir_q;
	word_t       res_q;
	word_t       alu_res;
	opcode_e     opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	word_t       imm_i;
	word_t       imm_s;
	word_t       imm_b;
	word_t       imm_u;
	word_t       imm_j;
	logic        is_lui, is_jal, is_addi, is_add, is_sub;
	logic        is_lw, is_sw, is_beq, is_bne, is_ebreak;
	logic        writes_rd;
	logic        take_branch;

	assign opcode = opcode_e'(ir_q[6:0]);
	assign funct3 = ir_q[14:12];
	assign funct7 = ir_q[31:25];

	assign imm_i = {{20{ir_q[31]}}, ir_q[31:20]};
	assign imm_s = {{20{ir_q[31]}}, ir_q[31:25], ir_q[11:7]};
	assign imm_b = {{19{ir_q[31]}}, ir_q[31], ir_q[7], ir_q[30:25], ir_q[11:8], 1'b0};
	assign imm_u = {ir_q[31:12], 12'b0};
	assign imm_j = {{11{ir_q[31]}}, ir_q[31], ir_q[19:12], ir_q[20], ir_q[30:21], 1'b0};

	// anything not matched here falls through as a no-op
	assign is_lui    = (opcode == OP_LUI);
	assign is_jal    = (opcode == OP_JAL);
	assign is_addi   = (opcode == OP_IMM) && (funct3 == 3'b000);
	assign is_add    = (opcode == OP_REG) && (funct3 == 3'b000) && (funct7 == 7'h00);
	assign is_sub    = (opcode == OP_REG) && (funct3 == 3'b000) && (funct7 == 7'h20);
	assign is_lw     = (opcode == OP_LOAD) && (funct3 == 3'b010);
	assign is_sw     = (opcode == OP_STORE) && (funct3 == 3'b010);
	assign is_beq    = (opcode == OP_BRANCH) && (funct3 == 3'b000);
	assign is_bne    = (opcode == OP_BRANCH) && (funct3 == 3'b001);
	assign is_ebreak = (opcode == OP_SYSTEM) && (ir_q[31:7] == 25'h000_2000);

	assign writes_rd   = is_lui | is_jal | is_addi | is_add | is_sub;
	assign take_branch = (is_beq && (rs1_data_i == rs2_data_i)) ||
		(is_bne && (rs1_data_i != rs2_data_i));

	always_comb begin
		alu_res = rs1_data_i + imm_i;
		if (is_lui) begin
			alu_res = imm_u;
		end else if (is_jal) begin
			alu_res = pc_q + 32'd4;
		end else if (is_add) begin
			alu_res = rs1_data_i + rs2_data_i;
		end else if (is_sub) begin
			alu_res = rs1_data_i - rs2_data_i;
		end
	end

	always_comb begin
		next_pc = pc_q + 32'd4;
		if (is_jal) begin
			next_pc = pc_q + imm_j;
		end else if (take_branch) begin
			next_pc = pc_q + imm_b;
		end
	end

	// dropping run_i parks the core between instructions
	assign resume_state = run_i ? S_FETCH : S_IDLE;

	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= S_IDLE;
			pc_q    <= `CPU_RESET_PC;
		end else begin
			case (state_q)
				S_IDLE: begin
					if (run_i) state_q <= S_FETCH;
				end
				S_FETCH: begin
					if (fetch_done_i) state_q <= S_EXEC;
				end
				S_EXEC: begin
					pc_q <= next_pc;
					if (is_ebreak) state_q <= S_HALT;
					else if (is_lw || is_sw) state_q <= S_MEM;
					else if (writes_rd) state_q <= S_WB;
					else state_q <= resume_state;
				end
				S_MEM: begin
					if (data_done_i) state_q <= is_lw ? S_WB : resume_state;
				end
				S_WB:    state_q <= resume_state;
				S_HALT:  state_q <= S_HALT;
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if ((state_q == S_FETCH) && fetch_done_i) ir_q <= fetch_rdata_i;
		if (state_q == S_EXEC) res_q <= alu_res;
		if ((state_q == S_MEM) && data_done_i) res_q <= data_rdata_i;
	end

	assign fetch_req_o  = (state_q == S_FETCH);
	assign fetch_addr_o = pc_q;

	// register file is quiet during S_MEM, so the address holds steady
	assign data_req_o   = (state_q == S_MEM);
	assign data_we_o    = is_sw;
	assign data_addr_o  = rs1_data_i + (is_sw ? imm_s : imm_i);
	assign data_wdata_o = rs2_data_i;
	assign data_strb_o  = 4'hf;

	assign rs1_addr_o = ir_q[19:15];
	assign rs2_addr_o = ir_q[24:20];
	assign rd_we_o    = (state_q == S_WB);
	assign rd_addr_o  = ir_q[11:7];
	assign rd_wdata_o = res_q;
	assign halted_o   = (state_q == S_HALT);

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic           clock,
	input  logic           arst_n_i,
	input  logic           host_req_i,
	input  logic           host_we_i,
	input  cpu_pkg::addr_t host_addr_i,
	input  cpu_pkg::word_t host_wdata_i,
	input  cpu_pkg::strb_t host_strb_i,
	output logic           host_done_o,
	output cpu_pkg::word_t host_rdata_o,
	input  logic           data_req_i,
	input  logic           data_we_i,
	input  cpu_pkg::addr_t data_addr_i,
	input  cpu_pkg::word_t data_wdata_i,
	input  cpu_pkg::strb_t data_strb_i,
	output logic           data_done_o,
	output cpu_pkg::word_t data_rdata_o,
	input  logic           fetch_req_i,
	input  cpu_pkg::addr_t fetch_addr_i,
	output logic           fetch_done_o,
	output cpu_pkg::word_t fetch_rdata_o,
	output logic           mem_en_o,
	output logic           mem_we_o,
	output cpu_pkg::addr_t mem_addr_o,
	output cpu_pkg::word_t mem_wdata_o,
	output cpu_pkg::strb_t mem_strb_o,
	input  cpu_pkg::word_t mem_rdata_i
);
	import cpu_pkg::*;

	logic  busy_q;
	logic  gnt_host_q, gnt_data_q, gnt_fetch_q;
	logic  pick_host, pick_data, pick_fetch;
	logic  sel_we;
	addr_t sel_addr;
	word_t sel_wdata;
	strb_t sel_strb;

	// fixed priority: host, then data, then fetch
	assign pick_host  = !busy_q && host_req_i;
	assign pick_data  = !busy_q && !host_req_i && data_req_i;
	assign pick_fetch = !busy_q && !host_req_i && !data_req_i && fetch_req_i;

	always_comb begin
		sel_we    = 1'b0;
		sel_addr  = fetch_addr_i;
		sel_wdata = '0;
		sel_strb  = '0;
		if (host_req_i) begin
			sel_we    = host_we_i;
			sel_addr  = host_addr_i;
			sel_wdata = host_wdata_i;
			sel_strb  = host_strb_i;
		end else if (data_req_i) begin
			sel_we    = data_we_i;
			sel_addr  = data_addr_i;
			sel_wdata = data_wdata_i;
			sel_strb  = data_strb_i;
		end
	end

	assign mem_en_o    = pick_host | pick_data | pick_fetch;
	assign mem_we_o    = mem_en_o & sel_we;
	assign mem_addr_o  = sel_addr;
	assign mem_wdata_o = sel_wdata;
	assign mem_strb_o  = sel_strb;

	// busy covers the response cycle, no new grant there
	always_ff @(posedge clock or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy_q      <= 1'b0;
			gnt_host_q  <= 1'b0;
			gnt_data_q  <= 1'b0;
			gnt_fetch_q <= 1'b0;
		end else begin
			busy_q      <= mem_en_o;
			gnt_host_q  <= pick_host;
			gnt_data_q  <= pick_data;
			gnt_fetch_q <= pick_fetch;
		end
	end

	assign host_done_o   = gnt_host_q;
	assign data_done_o   = gnt_data_q;
	assign fetch_done_o  = gnt_fetch_q;
	assign host_rdata_o  = gnt_host_q ? mem_rdata_i : '0;
	assign data_rdata_o  = gnt_data_q ? mem_rdata_i : '0;
	assign fetch_rdata_o = gnt_fetch_q ? mem_rdata_i : '0;

endmodule

//--- src/unified_mem.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module unified_mem #(
	parameter int WORDS = `CPU_MEM_WORDS,
	parameter int AW    = `CPU_MEM_AW
) (
	input  logic           clock,
	input  logic           en_i,
	input  logic           we_i,
	input  cpu_pkg::addr_t addr_i,
	input  cpu_pkg::word_t wdata_i,
	input  cpu_pkg::strb_t strb_i,
	output cpu_pkg::word_t rdata_o
);
	import cpu_pkg::*;

	word_t         mem [WORDS];
	logic [AW-1:0] idx;

	// word index, byte offset dropped
	assign idx = addr_i[AW+1:2];

	always_ff @(posedge clock) begin
		if (en_i) begin
			if (we_i) begin
				for (int b = 0; b < 4; b++) begin
					if (strb_i[b]) mem[idx][8*b +: 8] <= wdata_i[8*b +: 8];
				end
			end
			// old contents on a write cycle
			rdata_o <= mem[idx];
		end
	end

endmodule

//--- src/rv_soc.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module rv_soc (
	input  logic           clock,
	input  logic           arst_n_i,
	input  logic           run_i,
	output logic           halted_o,
	input  logic           host_req_i,
	input  logic           host_we_i,
	input  cpu_pkg::addr_t host_addr_i,
	input  cpu_pkg::word_t host_wdata_i,
	input  cpu_pkg::strb_t host_strb_i,
	output logic           host_done_o,
	output cpu_pkg::word_t host_rdata_o
);
	import cpu_pkg::*;

	// core fetch and data ports
	logic     freq, fdone;
	addr_t    faddr;
	word_t    frdata;
	logic     dreq, dwe, ddone;
	addr_t    daddr;
	word_t    dwdata, drdata;
	strb_t    dstrb;

	// register file
	reg_idx_t rs1_addr, rs2_addr, rd_addr;
	word_t    rs1_data, rs2_data, rd_wdata;
	logic     rd_we;

	// memory port
	logic     mem_en, mem_we;
	addr_t    mem_addr;
	word_t    mem_wdata, mem_rdata;
	strb_t    mem_strb;

	rv_core u_core (
		.clock         (clock),
		.arst_n_i      (arst_n_i),
		.run_i         (run_i),
		.fetch_req_o   (freq),
		.fetch_addr_o  (faddr),
		.fetch_done_i  (fdone),
		.fetch_rdata_i (frdata),
		.data_req_o    (dreq),
		.data_we_o     (dwe),
		.data_addr_o   (daddr),
		.data_wdata_o  (dwdata),
		.data_strb_o   (dstrb),
		.data_done_i   (ddone),
		.data_rdata_i  (drdata),
		.rs1_addr_o    (rs1_addr),
		.rs2_addr_o    (rs2_addr),
		.rs1_data_i    (rs1_data),
		.rs2_data_i    (rs2_data),
		.rd_we_o       (rd_we),
		.rd_addr_o     (rd_addr),
		.rd_wdata_o    (rd_wdata),
		.halted_o      (halted_o)
	);

	reg_file u_regs (
		.clock    (clock),
		.arst_n_i (arst_n_i),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data),
		.we_i     (rd_we),
		.waddr_i  (rd_addr),
		.wdata_i  (rd_wdata)
	);

	mem_arbiter u_arb (
		.clock         (clock),
		.arst_n_i      (arst_n_i),
		.host_req_i    (host_req_i),
		.host_we_i     (host_we_i),
		.host_addr_i   (host_addr_i),
		.host_wdata_i  (host_wdata_i),
		.host_strb_i   (host_strb_i),
		.host_done_o   (host_done_o),
		.host_rdata_o  (host_rdata_o),
		.data_req_i    (dreq),
		.data_we_i     (dwe),
		.data_addr_i   (daddr),
		.data_wdata_i  (dwdata),
		.data_strb_i   (dstrb),
		.data_done_o   (ddone),
		.data_rdata_o  (drdata),
		.fetch_req_i   (freq),
		.fetch_addr_i  (faddr),
		.fetch_done_o  (fdone),
		.fetch_rdata_o (frdata),
		.mem_en_o      (mem_en),
		.mem_we_o      (mem_we),
		.mem_addr_o    (mem_addr),
		.mem_wdata_o   (mem_wdata),
		.mem_strb_o    (mem_strb),
		.mem_rdata_i   (mem_rdata)
	);

	unified_mem #(
		.WORDS (`CPU_MEM_WORDS),
		.AW    (`CPU_MEM_AW)
	) u_mem (
		.clock   (clock),
		.en_i    (mem_en),
		.we_i    (mem_we),
		.addr_i  (mem_addr),
		.wdata_i (mem_wdata),
		.strb_i  (mem_strb),
		.rdata_o (mem_rdata)
	);

endmodule

//--- verification/tb_rv_soc.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_rv_soc;
	import cpu_pkg::*;

	localparam int unsigned SEED = 32'hc45f_00be;
	localparam int DONE_LIMIT = 64;
	localparam int HALT_LIMIT = 4000;
	localparam int READ_LIMIT = 400;
	localparam int DATA = 'h200;

	logic  clock;
	logic  arst_n_i;
	logic  run_i;
	logic  halted_o;
	logic  host_req_i;
	logic  host_we_i;
	addr_t host_addr_i;
	word_t host_wdata_i;
	strb_t host_strb_i;
	logic  host_done_o;
	word_t host_rdata_o;

	word_t prog [$];
	word_t loop_res [4];
	word_t uncontended [4];
	int    loop_n;
	int    errors;
	int    checks;
	int    tests;
	int    tests_failed;
	int    errors_at_start;
	string test_name;
	bit    timed_out;

	rv_soc i_dut (
		.clock        (clock),
		.arst_n_i     (arst_n_i),
		.run_i        (run_i),
		.halted_o     (halted_o),
		.host_req_i   (host_req_i),
		.host_we_i    (host_we_i),
		.host_addr_i  (host_addr_i),
		.host_wdata_i (host_wdata_i),
		.host_strb_i  (host_strb_i),
		.host_done_o  (host_done_o),
		.host_rdata_o (host_rdata_o)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// instruction encoders
	function automatic word_t lui(int rd, int imm20);
		return {imm20[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic word_t addi(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
	endfunction

	function automatic word_t add(int rd, int rs1, int rs2);
		return {7'h00, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
	endfunction

	function automatic word_t sub(int rd, int rs1, int rs2);
		return {7'h20, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
	endfunction

	function automatic word_t lw(int rd, int rs1, int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
	endfunction

	function automatic word_t sw(int rs2, int rs1, int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t branch(logic [2:0] f3, int rs1, int rs2, int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic word_t jal(int rd, int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	function automatic word_t ebreak();
		return 32'h0010_0073;
	endfunction

	// lui part of a lui/addi pair, rounded for the sign-extended low half
	function automatic int upper_imm(word_t v);
		word_t t;
		t = v + 32'h800;
		return int'(t >> 12);
	endfunction

	function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
		word_t res;
		res = old_w;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
		end
		return res;
	endfunction

	function automatic word_t marker(int a);
		return 32'h5a5a_0000 ^ word_t'(a);
	endfunction

	task automatic check_word(string what, word_t exp, word_t act);
		checks++;
		assert (act === exp) else begin
			$display("Fail %s (%s): expected %08h, actual %08h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic apply_reset();
		arst_n_i = 1'b0;
		run_i    = 1'b0;
		repeat (4) @(posedge clock);
		#2;
		arst_n_i = 1'b1;
	endtask

	task automatic host_access(logic we, addr_t addr, word_t wdata, strb_t strb,
			output word_t rdata);
		int n;
		rdata = '0;
		if (timed_out) return;
		host_req_i   = 1'b1;
		host_we_i    = we;
		host_addr_i  = addr;
		host_wdata_i = wdata;
		host_strb_i  = strb;
		n = 0;
		do begin
			@(posedge clock);
			#1;
			n++;
		end while (!host_done_o && (n < DONE_LIMIT));
		if (host_done_o) begin
			rdata = host_rdata_o;
		end else begin
			$display("Timeout: host access to %08h got no done pulse", addr);
			timed_out = 1'b1;
			errors++;
		end
		#1;
		host_req_i = 1'b0;
		host_we_i  = 1'b0;
	endtask

	task automatic host_write(addr_t addr, word_t data, strb_t strb);
		word_t unused;
		host_access(1'b1, addr, data, strb, unused);
	endtask

	task automatic host_read(addr_t addr, output word_t data);
		host_access(1'b0, addr, '0, '0, data);
	endtask

	task automatic load_program();
		for (int i = 0; i < prog.size(); i++) begin
			host_write(`CPU_RESET_PC + addr_t'(4 * i), prog[i], 4'hf);
		end
	endtask

	task automatic wait_halt(string what);
		int n;
		if (timed_out) return;
		n = 0;
		while (!halted_o && (n < HALT_LIMIT)) begin
			@(posedge clock);
			#2;
			n++;
		end
		if (!halted_o) begin
			$display("Timeout: %s never raised halted_o", what);
			timed_out = 1'b1;
			errors++;
		end
	endtask

	task automatic begin_test(string name);
		errors_at_start = errors;
		test_name = name;
	endtask

	task automatic end_test();
		tests++;
		if (errors == errors_at_start) begin
			$display("test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	// sum 1..n, two skipped stores, jal link stored at DATA+4
	task automatic build_loop_program(int n);
		prog.delete();
		prog.push_back(addi(1, 0, n));
		prog.push_back(addi(2, 0, 0));
		prog.push_back(add(2, 2, 1));
		prog.push_back(addi(1, 1, -1));
		prog.push_back(branch(3'b001, 1, 0, -8));
		prog.push_back(branch(3'b000, 0, 0, 8));
		prog.push_back(sw(2, 0, DATA + 8));
		prog.push_back(sw(2, 0, DATA));
		prog.push_back(jal(3, 8));
		prog.push_back(sw(2, 0, DATA + 12));
		prog.push_back(sw(3, 0, DATA + 4));
		prog.push_back(ebreak());
	endtask

	task automatic run_loop_program();
		build_loop_program(loop_n);
		load_program();
		for (int i = 0; i < 4; i++) begin
			host_write(addr_t'(DATA + 4 * i), marker(DATA + 4 * i), 4'hf);
		end
		run_i = 1'b1;
	endtask

	task automatic read_loop_results();
		for (int i = 0; i < 4; i++) begin
			host_read(addr_t'(DATA + 4 * i), loop_res[i]);
		end
	endtask

	task automatic reset_and_strobes();
		addr_t addr;
		word_t old_w;
		word_t new_w;
		word_t got;
		strb_t strb;
		begin_test("reset and strobes");
		apply_reset();
		check_word("halted after reset", 32'h0, word_t'(halted_o));
		check_word("host done after reset", 32'h0, word_t'(host_done_o));
		for (int i = 0; i < 8; i++) begin
			addr  = 32'h300 + (($urandom() & 32'h3f) << 2);
			old_w = $urandom();
			new_w = $urandom();
			strb  = strb_t'($urandom());
			host_write(addr, old_w, 4'hf);
			host_write(addr, new_w, strb);
			host_read(addr, got);
			check_word($sformatf("strobed write %08h", addr), merge_bytes(old_w, new_w, strb), got);
		end
		end_test();
	endtask

	task automatic arithmetic();
		word_t a;
		word_t b;
		word_t got;
		word_t exp [6];
		int    imm;
		int    u;
		begin_test("arithmetic");
		a   = $urandom();
		b   = $urandom();
		imm = int'($urandom_range(4095, 0)) - 2048;
		u   = int'($urandom() & 32'hfffff);
		exp[0] = a;
		exp[1] = b;
		exp[2] = a + b;
		exp[3] = a - b;
		exp[4] = a + word_t'(imm);
		exp[5] = word_t'(u) << 12;
		apply_reset();
		prog.delete();
		prog.push_back(lui(1, upper_imm(a)));
		prog.push_back(addi(1, 1, int'(a)));
		prog.push_back(lui(2, upper_imm(b)));
		prog.push_back(addi(2, 2, int'(b)));
		prog.push_back(add(3, 1, 2));
		prog.push_back(sub(4, 1, 2));
		prog.push_back(addi(5, 1, imm));
		prog.push_back(lui(6, u));
		for (int r = 1; r <= 6; r++) begin
			prog.push_back(sw(r, 0, DATA + 4 * (r - 1)));
		end
		prog.push_back(ebreak());
		load_program();
		run_i = 1'b1;
		wait_halt("arithmetic program");
		for (int i = 0; i < 6; i++) begin
			host_read(addr_t'(DATA + 4 * i), got);
			check_word($sformatf("arithmetic x%0d", i + 1), exp[i], got);
		end
		end_test();
	endtask

	task automatic branches_and_jumps();
		begin_test("branches and jumps");
		loop_n = int'($urandom_range(20, 1));
		apply_reset();
		run_loop_program();
		wait_halt("loop program");
		read_loop_results();
		check_word("loop sum", word_t'(loop_n * (loop_n + 1) / 2), loop_res[0]);
		check_word("jal link", `CPU_RESET_PC + 32'd36, loop_res[1]);
		check_word("skipped by beq", marker(DATA + 8), loop_res[2]);
		check_word("skipped by jal", marker(DATA + 12), loop_res[3]);
		uncontended = loop_res;
		end_test();
	endtask

	task automatic loads_stores_x0();
		word_t w;
		word_t got;
		begin_test("loads, stores and x0");
		w = $urandom();
		apply_reset();
		host_write(addr_t'(DATA + 'h40), w, 4'hf);
		host_write(addr_t'(DATA + 'h44), marker(DATA + 'h44), 4'hf);
		host_write(addr_t'(DATA + 'h48), marker(DATA + 'h48), 4'hf);
		prog.delete();
		prog.push_back(lw(5, 0, DATA + 'h40));
		prog.push_back(sw(5, 0, DATA + 'h44));
		prog.push_back(addi(0, 0, 123));
		prog.push_back(lui(0, 'habcde));
		prog.push_back(add(0, 5, 5));
		prog.push_back(sw(0, 0, DATA + 'h48));
		prog.push_back(ebreak());
		load_program();
		run_i = 1'b1;
		wait_halt("load/store program");
		host_read(addr_t'(DATA + 'h44), got);
		check_word("lw then sw copy", w, got);
		host_read(addr_t'(DATA + 'h48), got);
		check_word("sw of x0", 32'h0, got);
		end_test();
	endtask

	task automatic contention();
		word_t cval;
		word_t got;
		int    reads;
		begin_test("contention");
		cval = $urandom();
		apply_reset();
		host_write(addr_t'(DATA + 'h80), cval, 4'hf);
		run_loop_program();
		reads = 0;
		while (!halted_o && !timed_out && (reads < READ_LIMIT)) begin
			host_read(addr_t'(DATA + 'h80), got);
			check_word("contended host read", cval, got);
			reads++;
			// host must stay off for a full idle arbiter cycle
			repeat (2 + $urandom_range(2, 0)) @(posedge clock);
			#2;
		end
		wait_halt("contended loop program");
		read_loop_results();
		for (int i = 0; i < 4; i++) begin
			check_word($sformatf("contended result %0d", i), uncontended[i], loop_res[i]);
		end
		end_test();
	endtask

	task automatic halt_behavior();
		word_t late;
		word_t got;
		begin_test("halt");
		apply_reset();
		host_write(addr_t'(DATA + 'h64), marker(DATA + 'h64), 4'hf);
		prog.delete();
		prog.push_back(addi(1, 0, 5));
		prog.push_back(sw(1, 0, DATA + 'h60));
		prog.push_back(ebreak());
		prog.push_back(addi(0, 0, 0));
		load_program();
		run_i = 1'b1;
		wait_halt("halt program");
		late = sw(1, 0, DATA + 'h64);
		host_write(`CPU_RESET_PC + 32'd12, late, 4'hf);
		for (int i = 0; i < 16; i++) begin
			@(posedge clock);
			#2;
			check_word("halted held", 32'h1, word_t'(halted_o));
		end
		host_read(`CPU_RESET_PC + 32'd12, got);
		check_word("word after ebreak", late, got);
		host_read(addr_t'(DATA + 'h64), got);
		check_word("late store not executed", marker(DATA + 'h64), got);
		host_read(addr_t'(DATA + 'h60), got);
		check_word("store before ebreak", 32'd5, got);
		end_test();
	endtask

	initial begin
		void'($urandom(SEED));
		arst_n_i     = 1'b0;
		run_i        = 1'b0;
		host_req_i   = 1'b0;
		host_we_i    = 1'b0;
		host_addr_i  = '0;
		host_wdata_i = '0;
		host_strb_i  = '0;
		errors       = 0;
		checks       = 0;
		tests        = 0;
		tests_failed = 0;
		test_name    = "";
		timed_out    = 1'b0;

		reset_and_strobes();
		arithmetic();
		branches_and_jumps();
		loads_stores_x0();
		contention();
		halt_behavior();

		$display("%0d tests, %0d failed, %0d checks, %0d errors",
			tests, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+include
src/cpu_pkg.sv
src/reg_file.sv
src/rv_core.sv
src/mem_arbiter.sv
src/unified_mem.sv
src/rv_soc.sv
verification/tb_rv_soc.sv

//--- Makefile
TOP       ?= tb_rv_soc
FILELIST  ?= vlog.f
LOG       ?= sim.log
SEED      ?= 1
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
